//--- all.f
src/ppu_pkg.sv
src/ppu_video_timing.sv
src/ppu_reg_bus.sv
src/ppu_vram.sv
src/ppu_bg_pipeline.sv
src/nes_ppu_lite.sv
sim/nes_ppu_props.sv
sim/tb_nes_ppu_lite.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_nes_ppu_lite -o tb_sim

output="$(./obj_dir/tb_sim 2>&1 || true)"
echo "$output"

if grep -q "ALL CHECKS PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

//--- sim/tb_nes_ppu_lite.sv
// Testbench for the PPU core: drives the AXI4-Lite port, mirrors VRAM and
// registers in a model and checks reads, VBlank, NMI and background pixels
module tb_nes_ppu_lite;
    timeunit 1ns;
    timeprecision 1ps;
    import ppu_pkg::*;

    // Two frames plus bus traffic
    localparam int MAX_CYCLES = 250000;

    logic        cpu_clk;
    logic        rst_n;
    logic        awvalid;
    logic        awready;
    logic [4:0]  awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [4:0]  araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic [5:0]  color;
    logic        hsync;
    logic        vsync;
    logic        de;
    logic        nmi;

    // Reference model state
    logic [7:0]  m_nt [2048];
    logic [5:0]  m_pal [32];
    logic [13:0] m_vaddr;
    logic [7:0]  m_buf;
    logic        m_latch;
    logic        m_incr32;
    logic [7:0]  m_sx;
    logic [7:0]  m_sy;
    int          cycles;

    nes_ppu_lite nes_ppu_lite_i (
        .cpu_clk (cpu_clk), .rst_n (rst_n),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid  (wvalid),  .wready  (wready),  .wdata  (wdata), .wstrb (wstrb),
        .bvalid  (bvalid),  .bready  (bready),  .bresp  (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid  (rvalid),  .rready  (rready),  .rdata  (rdata), .rresp (rresp),
        .color   (color),   .hsync   (hsync),   .vsync  (vsync),
        .de      (de),      .nmi     (nmi)
    );

    initial begin
        cpu_clk = 1'b0;
        forever #10 cpu_clk = ~cpu_clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge cpu_clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    end

    task automatic check_value(input logic [7:0] got, input logic [7:0] exp, input string what);
        assert (got === exp) else begin
            $display("FAIL %0t: %s read %02h, expected %02h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "check failed");
        end
    endtask

    function automatic logic [13:0] next_addr(input logic [13:0] a);
        return a + (m_incr32 ? 14'd32 : 14'd1);
    endfunction

    // ============================================================
    // AXI transfers, with the response held back one cycle
    // ============================================================
    task automatic bus_write(input ppu_reg_e idx, input logic [7:0] val);
        @(posedge cpu_clk);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= {idx, 2'b00};
        wdata   <= {24'h000000, val};
        @(negedge cpu_clk);
        while (!awready) @(negedge cpu_clk);
        check_value({7'd0, wready}, 8'h01, "wready with awready");
        @(posedge cpu_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge cpu_clk);
        while (!bvalid) @(negedge cpu_clk);
        check_value({6'd0, bresp}, 8'h00, "bresp");
        @(posedge cpu_clk);
        bready <= 1'b1;
        @(posedge cpu_clk);
        bready <= 1'b0;
    endtask

    task automatic bus_read(input ppu_reg_e idx, output logic [7:0] val);
        @(posedge cpu_clk);
        arvalid <= 1'b1;
        araddr  <= {idx, 2'b00};
        @(negedge cpu_clk);
        while (!arready) @(negedge cpu_clk);
        @(posedge cpu_clk);
        arvalid <= 1'b0;
        @(negedge cpu_clk);
        while (!rvalid) @(negedge cpu_clk);
        val = rdata[7:0];
        check_value({6'd0, rresp}, 8'h00, "rresp");
        check_value({7'd0, |rdata[31:8]}, 8'h00, "rdata upper bits");
        @(posedge cpu_clk);
        rready <= 1'b1;
        @(posedge cpu_clk);
        rready <= 1'b0;
    endtask

    // ============================================================
    // Register access through the model
    // ============================================================
    task automatic reg_write(input ppu_reg_e idx, input logic [7:0] val);
        bus_write(idx, val);
        case (idx)
            REG_CTRL: m_incr32 = val[2];
            REG_SCROLL: begin
                if (!m_latch) m_sx = val;
                else m_sy = val;
                m_latch = !m_latch;
            end
            REG_ADDR: begin
                if (!m_latch) m_vaddr[13:8] = val[5:0];
                else m_vaddr[7:0] = val;
                m_latch = !m_latch;
            end
            REG_DATA: begin
                if (m_vaddr >= PALETTE_BASE) m_pal[m_vaddr[4:0]] = val[5:0];
                else if (m_vaddr >= CHR_LIMIT) m_nt[m_vaddr[10:0]] = val;
                m_vaddr = next_addr(m_vaddr);
            end
            default: begin
            end
        endcase
    endtask

    task automatic set_addr(input logic [13:0] a);
        reg_write(REG_ADDR, {2'b00, a[13:8]});
        reg_write(REG_ADDR, a[7:0]);
    endtask

    // Nametable reads are buffered, palette reads are not
    task automatic read_data_check(input string what);
        logic [7:0] got;
        logic [7:0] exp;
        bus_read(REG_DATA, got);
        if (m_vaddr < CHR_LIMIT) begin
            exp   = m_buf;
            m_buf = 8'h00;
        end else if (m_vaddr >= PALETTE_BASE) begin
            exp   = {2'b00, m_pal[m_vaddr[4:0]]};
            m_buf = exp;
        end else begin
            exp   = m_buf;
            m_buf = m_nt[m_vaddr[10:0]];
        end
        m_vaddr = next_addr(m_vaddr);
        check_value(got, exp, what);
    endtask

    function automatic logic [5:0] expected_pixel(input int line, input int dot);
        logic [4:0] tx;
        logic [4:0] ty;
        logic [7:0] t;
        tx = 5'(dot / 8) + m_sx[7:3];
        ty = 5'(line / 8) + m_sy[7:3];
        t  = m_nt[{1'b0, ty, tx}];
        return m_pal[{3'b000, t[1:0]}];
    endfunction

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        logic [7:0] got;
        int         line;
        int         dot;
        void'($urandom(32'h04deeda2));
        rst_n = 1'b0;
        awvalid = 1'b0;
        awaddr = 5'd0;
        wvalid = 1'b0;
        wdata = 32'd0;
        wstrb = 4'hF;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = 5'd0;
        rready = 1'b0;
        m_vaddr = 14'd0;
        m_buf = 8'h00;
        m_latch = 1'b0;
        m_incr32 = 1'b0;
        m_sx = 8'h00;
        m_sy = 8'h00;
        repeat (16) @(posedge cpu_clk);
        rst_n <= 1'b1;

        // Buffered nametable reads, increment 1
        set_addr(14'h2000);
        for (int i = 0; i < 16; i++) reg_write(REG_DATA, 8'($urandom()));
        set_addr(14'h2000);
        for (int i = 0; i < 17; i++) read_data_check("nametable");

        // Increment by 32
        reg_write(REG_CTRL, 8'h04);
        set_addr(14'h2400);
        for (int i = 0; i < 8; i++) reg_write(REG_DATA, 8'($urandom()));
        set_addr(14'h2400);
        for (int i = 0; i < 9; i++) read_data_check("nametable step 32");

        // Palette reads come back at once
        reg_write(REG_CTRL, 8'h00);
        set_addr(PALETTE_BASE);
        for (int i = 0; i < 32; i++) reg_write(REG_DATA, 8'($urandom()));
        set_addr(PALETTE_BASE);
        for (int i = 0; i < 32; i++) read_data_check("palette");

        // Background setup
        set_addr(14'h2000);
        for (int i = 0; i < 1024; i++) reg_write(REG_DATA, 8'($urandom()));
        reg_write(REG_MASK, 8'h08);
        reg_write(REG_SCROLL, 8'($urandom()));
        reg_write(REG_SCROLL, 8'($urandom()));

        // VBlank flag and NMI gating
        @(negedge cpu_clk);
        while (vsync) @(negedge cpu_clk);
        while (!vsync) @(negedge cpu_clk);
        check_value({7'd0, nmi}, 8'h00, "nmi with nmi_en clear");
        reg_write(REG_CTRL, 8'h80);
        repeat (2) @(negedge cpu_clk);
        check_value({7'd0, nmi}, 8'h01, "nmi with nmi_en set");
        bus_read(REG_STATUS, got);
        m_latch = 1'b0;
        check_value(got, 8'h80, "first status");
        bus_read(REG_STATUS, got);
        check_value(got, 8'h00, "second status");
        repeat (2) @(negedge cpu_clk);
        check_value({7'd0, nmi}, 8'h00, "nmi after status read");

        // Background pixels over one frame, positions counted from de edges
        while (!de) @(negedge cpu_clk);
        line = 0;
        dot = 0;
        while (line < 240) begin
            if (de) begin
                check_value({2'b00, color}, {2'b00, expected_pixel(line, dot)}, "pixel");
                dot++;
            end else begin
                check_value({2'b00, color}, {2'b00, BLANK_COLOR}, "blank color");
                if (dot != 0) begin
                    line++;
                    dot = 0;
                end
            end
            @(negedge cpu_clk);
        end

        // Second VBlank is left for the pre-render line to clear
        while (!vsync) @(negedge cpu_clk);
        check_value({7'd0, nmi}, 8'h01, "nmi in second vblank");
        while (!de) @(negedge cpu_clk);
        check_value({7'd0, nmi}, 8'h00, "nmi at frame start");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- sim/nes_ppu_props.sv
// Concurrent checks on frame timing and the AXI response handshake,
// bound into the PPU top level
module nes_ppu_props (
    input logic cpu_clk,
    input logic rst_n,
    input logic hsync,
    input logic vsync,
    input logic de,
    input logic awvalid,
    input logic wvalid,
    input logic bvalid,
    input logic bready,
    input logic arvalid,
    input logic rvalid,
    input logic rready
);
    timeunit 1ns;
    timeprecision 1ps;

    logic hsync_q;
    logic vsync_q;
    logic de_q;
    logic hs_seen;
    logic vs_seen;
    int   hs_len;
    int   hs_per;
    int   vs_len;
    int   vs_per;
    int   de_len;
    int   de_lines;

    // ============================================================
    // Run lengths and periods of the video strobes
    // ============================================================
    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync_q  <= 1'b0;
            vsync_q  <= 1'b0;
            de_q     <= 1'b0;
            hs_seen  <= 1'b0;
            vs_seen  <= 1'b0;
            hs_len   <= 0;
            hs_per   <= 0;
            vs_len   <= 0;
            vs_per   <= 0;
            de_len   <= 0;
            de_lines <= 0;
        end else begin
            hsync_q <= hsync;
            vsync_q <= vsync;
            de_q    <= de;
            hs_len  <= hsync ? hs_len + 1 : 0;
            vs_len  <= vsync ? vs_len + 1 : 0;
            de_len  <= de ? de_len + 1 : 0;
            hs_per  <= (hsync && !hsync_q) ? 1 : hs_per + 1;
            vs_per  <= (vsync && !vsync_q) ? 1 : vs_per + 1;
            if (hsync && !hsync_q) begin
                hs_seen <= 1'b1;
            end
            if (vsync && !vsync_q) begin
                vs_seen  <= 1'b1;
                de_lines <= 0;
            end else if (de && !de_q) begin
                de_lines <= de_lines + 1;
            end
        end
    end

    // 24 dots of hsync every 341, 3 lines of vsync every 262
    a_hsync_len: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        $fell(hsync) |-> hs_len == 24) else $error("hsync width wrong");
    a_hsync_per: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        $rose(hsync) && hs_seen |-> hs_per == 341) else $error("hsync period wrong");
    a_vsync_len: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        $fell(vsync) |-> vs_len == 3 * 341) else $error("vsync width wrong");
    a_vsync_per: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        $rose(vsync) && vs_seen |-> vs_per == 341 * 262) else $error("vsync period wrong");
    a_de_len: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        $fell(de) |-> de_len == 256) else $error("de width wrong");
    a_de_lines: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        $rose(vsync) |-> de_lines == 240) else $error("visible line count wrong");

    // ============================================================
    // Response handshake
    // ============================================================
    a_b_hold: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid) else $error("bvalid dropped early");
    a_r_hold: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid) else $error("rvalid dropped early");
    a_b_cause: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        $rose(bvalid) |-> $past(awvalid && wvalid)) else $error("write response without request");
    a_r_cause: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        $rose(rvalid) |-> $past(arvalid)) else $error("read response without request");

endmodule

bind nes_ppu_lite nes_ppu_props nes_ppu_props_i (
    .cpu_clk (cpu_clk),
    .rst_n   (rst_n),
    .hsync   (hsync),
    .vsync   (vsync),
    .de      (de),
    .awvalid (awvalid),
    .wvalid  (wvalid),
    .bvalid  (bvalid),
    .bready  (bready),
    .arvalid (arvalid),
    .rvalid  (rvalid),
    .rready  (rready)
);

//--- src/nes_ppu_lite.sv
// PPU core top level: AXI4-Lite register port in, 6-bit color index,
// sync, display enable and NMI out, one dot per cpu_clk
module nes_ppu_lite #(
    parameter int DOTS_PER_LINE   = ppu_pkg::DOTS_PER_LINE_DEF,
    parameter int LINES_PER_FRAME = ppu_pkg::LINES_PER_FRAME_DEF
) (
    input  logic        cpu_clk,
    input  logic        rst_n,
    // AXI4-Lite slave
    input  logic        awvalid,
    output logic        awready,
    input  logic [4:0]  awaddr,
    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,
    input  logic        arvalid,
    output logic        arready,
    input  logic [4:0]  araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    // Video and interrupt
    output logic [5:0]  color,
    output logic        hsync,
    output logic        vsync,
    output logic        de,
    output logic        nmi
);
    import ppu_pkg::*;

    timing_t       timing;
    logic          vblank_set;
    logic          vblank_clr;
    cpu_vram_req_t vram_req;
    logic [7:0]    vram_rdata;
    render_req_t   render_req;
    render_rsp_t   render_rsp;
    logic          render_en;
    logic [7:0]    scroll_x;
    logic [7:0]    scroll_y;

    // ==========================================================
    // Frame timing
    // ==========================================================
    ppu_video_timing #(
        .DOTS_PER_LINE   (DOTS_PER_LINE),
        .LINES_PER_FRAME (LINES_PER_FRAME)
    ) ppu_video_timing_i (
        .cpu_clk    (cpu_clk),
        .rst_n      (rst_n),
        .timing     (timing),
        .vblank_set (vblank_set),
        .vblank_clr (vblank_clr)
    );

    // ==========================================================
    // Register port
    // ==========================================================
    ppu_reg_bus ppu_reg_bus_i (
        .cpu_clk    (cpu_clk),
        .rst_n      (rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .vblank_set (vblank_set),
        .vblank_clr (vblank_clr),
        .vram_req   (vram_req),
        .vram_rdata (vram_rdata),
        .ctrl       (),
        .render_en  (render_en),
        .scroll_x   (scroll_x),
        .scroll_y   (scroll_y),
        .nmi        (nmi)
    );

    // ==========================================================
    // Memories and background
    // ==========================================================
    ppu_vram ppu_vram_i (
        .cpu_clk    (cpu_clk),
        .cpu_req    (vram_req),
        .cpu_rdata  (vram_rdata),
        .render_req (render_req),
        .render_rsp (render_rsp)
    );

    ppu_bg_pipeline ppu_bg_pipeline_i (
        .cpu_clk    (cpu_clk),
        .rst_n      (rst_n),
        .timing     (timing),
        .render_en  (render_en),
        .scroll_x   (scroll_x),
        .scroll_y   (scroll_y),
        .render_req (render_req),
        .render_rsp (render_rsp),
        .color      (color),
        .hsync      (hsync),
        .vsync      (vsync),
        .de         (de)
    );

endmodule

//--- src/ppu_bg_pipeline.sv
// Scrolled background: fetches the tile under each dot, maps it to a palette
// entry and delays sync and enable by two cycles to line up with the color
module ppu_bg_pipeline (
    input  logic                 cpu_clk,
    input  logic                 rst_n,
    input  ppu_pkg::timing_t     timing,
    input  logic                 render_en,
    input  logic [7:0]           scroll_x,
    input  logic [7:0]           scroll_y,
    output ppu_pkg::render_req_t render_req,
    input  ppu_pkg::render_rsp_t render_rsp,
    output logic [5:0]           color,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 de
);
    import ppu_pkg::*;

    logic [4:0] tile_x;
    logic [4:0] tile_y;
    logic [1:0] hsync_d;
    logic [1:0] vsync_d;
    logic [1:0] de_d;

    // Coarse scroll wraps within a 32x32 tile map
    assign tile_x = timing.dot[7:3] + scroll_x[7:3];
    assign tile_y = timing.line[7:3] + scroll_y[7:3];

    // ==========================================================
    // Fetch stages
    // ==========================================================
    // Stage 1 issues the tile address, stage 2 turns the returned tile
    // into a palette index; value 0 falls on the universal color
    always_comb begin
        render_req.nt_addr = NT_ADDR_W'({tile_y, tile_x});
        if (render_en) begin
            render_req.pal_idx = PAL_ADDR_W'(render_rsp.tile[1:0]);
        end else begin
            render_req.pal_idx = '0;
        end
    end

    // ==========================================================
    // Sync alignment
    // ==========================================================
    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync_d <= 2'b00;
            vsync_d <= 2'b00;
            de_d    <= 2'b00;
        end else begin
            hsync_d <= {hsync_d[0], timing.hsync};
            vsync_d <= {vsync_d[0], timing.vsync};
            de_d    <= {de_d[0], timing.de};
        end
    end

    assign hsync = hsync_d[1];
    assign vsync = vsync_d[1];
    assign de    = de_d[1];

    // Stage 3 color arrives with the delayed enable
    assign color = de_d[1] ? render_rsp.color : BLANK_COLOR;

endmodule

//--- src/ppu_vram.sv
// Nametable and palette memories; the CPU port reads combinationally,
// the render port returns tile and color one cycle after the request
module ppu_vram (
    input  logic                   cpu_clk,
    input  ppu_pkg::cpu_vram_req_t cpu_req,
    output logic [7:0]             cpu_rdata,
    input  ppu_pkg::render_req_t   render_req,
    output ppu_pkg::render_rsp_t   render_rsp
);
    import ppu_pkg::*;

    logic [7:0]            nt_mem  [2**NT_ADDR_W];
    logic [5:0]            pal_mem [2**PAL_ADDR_W];
    logic                  cpu_pal;
    logic [NT_ADDR_W-1:0]  cpu_nt_addr;
    logic [PAL_ADDR_W-1:0] cpu_pal_addr;

    // Nametables mirror through the low 11 bits
    assign cpu_pal      = (cpu_req.addr >= PALETTE_BASE);
    assign cpu_nt_addr  = cpu_req.addr[NT_ADDR_W-1:0];
    assign cpu_pal_addr = cpu_req.addr[PAL_ADDR_W-1:0];

    // ==========================================================
    // CPU port
    // ==========================================================
    always_ff @(posedge cpu_clk) begin
        if (cpu_req.we) begin
            if (cpu_pal) begin
                pal_mem[cpu_pal_addr] <= cpu_req.wdata[5:0];
            end else begin
                nt_mem[cpu_nt_addr] <= cpu_req.wdata;
            end
        end
    end

    // Palette entries are 6-bit color indices
    assign cpu_rdata = cpu_pal ? {2'b00, pal_mem[cpu_pal_addr]} : nt_mem[cpu_nt_addr];

    // ==========================================================
    // Render port
    // ==========================================================
    always_ff @(posedge cpu_clk) begin
        render_rsp.tile  <= nt_mem[render_req.nt_addr];
        render_rsp.color <= pal_mem[render_req.pal_idx];
    end

endmodule

//--- src/ppu_reg_bus.sv
// AXI4-Lite slave holding the PPU register window, the shared write latch,
// the VBlank flag and the PPUDATA port into VRAM and palette
module ppu_reg_bus (
    input  logic                   cpu_clk,
    input  logic                   rst_n,
    // Write address, data and response
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [4:0]             awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [31:0]            wdata,
    input  logic [3:0]             wstrb,
    output logic                   bvalid,
    input  logic                   bready,
    output logic [1:0]             bresp,
    // Read address and data
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [4:0]             araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    // Frame events
    input  logic                   vblank_set,
    input  logic                   vblank_clr,
    // CPU side of VRAM
    output ppu_pkg::cpu_vram_req_t vram_req,
    input  logic [7:0]             vram_rdata,
    // Render controls
    output ppu_pkg::ppu_ctrl_t     ctrl,
    output logic                   render_en,
    output logic [7:0]             scroll_x,
    output logic [7:0]             scroll_y,
    output logic                   nmi
);
    import ppu_pkg::*;

    ppu_reg_e               wr_reg;
    ppu_reg_e               rd_reg;
    logic                   wr_acc;
    logic                   rd_acc;
    logic [7:0]             wr_byte;
    logic [7:0]             mask;
    logic                   vblank;
    logic                   latch;
    logic [VRAM_ADDR_W-1:0] vaddr;
    logic [VRAM_ADDR_W-1:0] vaddr_next;
    logic [7:0]             rd_buf;
    logic [7:0]             buf_next;
    logic [7:0]             rd_byte;
    logic [7:0]             rdata_q;

    // ==========================================================
    // Handshake
    // ==========================================================
    // Register writes are byte wide, so wstrb carries no information
    assign wr_reg  = ppu_reg_e'(awaddr[4:2]);
    assign rd_reg  = ppu_reg_e'(araddr[4:2]);
    assign wr_byte = wdata[7:0];

    // Address and data are taken together, only with no response pending
    assign wr_acc  = awvalid && wvalid && !bvalid;
    assign rd_acc  = arvalid && !rvalid;
    assign awready = wr_acc;
    assign wready  = wr_acc;
    assign arready = !rvalid;
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;
    assign rdata   = {24'h000000, rdata_q};

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_acc) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_acc) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (rd_acc) begin
            rdata_q <= rd_byte;
        end
    end

    // ==========================================================
    // PPUDATA path
    // ==========================================================
    assign vaddr_next = vaddr + (ctrl.incr32 ? VRAM_ADDR_W'(32) : VRAM_ADDR_W'(1));

    // Pattern space is read-only and reads as zero
    always_comb begin
        vram_req.we    = wr_acc && (wr_reg == REG_DATA) && (vaddr >= CHR_LIMIT);
        vram_req.addr  = vaddr;
        vram_req.wdata = wr_byte;
    end

    assign buf_next = (vaddr < CHR_LIMIT) ? 8'h00 : vram_rdata;

    // Palette reads bypass the buffer, everything else returns the old byte
    always_comb begin
        case (rd_reg)
            REG_CTRL:   rd_byte = ctrl;
            REG_MASK:   rd_byte = mask;
            REG_STATUS: rd_byte = {vblank, 7'b0000000};
            REG_DATA:   rd_byte = (vaddr >= PALETTE_BASE) ? vram_rdata : rd_buf;
            default:    rd_byte = 8'h00;
        endcase
    end

    // ==========================================================
    // Register file
    // ==========================================================
    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl     <= '0;
            mask     <= 8'h00;
            scroll_x <= 8'h00;
            scroll_y <= 8'h00;
            vaddr    <= '0;
            latch    <= 1'b0;
            rd_buf   <= 8'h00;
            vblank   <= 1'b0;
            nmi      <= 1'b0;
        end else begin
            if (wr_acc) begin
                case (wr_reg)
                    REG_CTRL: ctrl <= ppu_ctrl_t'(wr_byte);
                    REG_MASK: mask <= wr_byte;
                    REG_SCROLL: begin
                        if (!latch) begin
                            scroll_x <= wr_byte;
                        end else begin
                            scroll_y <= wr_byte;
                        end
                        latch <= !latch;
                    end
                    // High byte first
                    REG_ADDR: begin
                        if (!latch) begin
                            vaddr[VRAM_ADDR_W-1:8] <= wr_byte[VRAM_ADDR_W-9:0];
                        end else begin
                            vaddr[7:0] <= wr_byte;
                        end
                        latch <= !latch;
                    end
                    REG_DATA: vaddr <= vaddr_next;
                    default: begin
                    end
                endcase
            end
            // Read side effects land on the acceptance edge
            if (rd_acc) begin
                case (rd_reg)
                    REG_STATUS: begin
                        vblank <= 1'b0;
                        latch  <= 1'b0;
                    end
                    REG_DATA: begin
                        rd_buf <= buf_next;
                        vaddr  <= vaddr_next;
                    end
                    default: begin
                    end
                endcase
            end
            if (vblank_clr) begin
                vblank <= 1'b0;
            end
            if (vblank_set) begin
                vblank <= 1'b1;
            end
            nmi <= vblank && ctrl.nmi_en;
        end
    end

    // Background or sprite enable
    assign render_en = mask[3] || mask[4];

endmodule

//--- src/ppu_video_timing.sv
// Dot and line counters for the PPU frame; decodes sync, display enable
// and the one-cycle VBlank start and end events
module ppu_video_timing #(
    parameter int DOTS_PER_LINE   = ppu_pkg::DOTS_PER_LINE_DEF,
    parameter int LINES_PER_FRAME = ppu_pkg::LINES_PER_FRAME_DEF
) (
    input  logic             cpu_clk,
    input  logic             rst_n,
    output ppu_pkg::timing_t timing,
    output logic             vblank_set,
    output logic             vblank_clr
);
    import ppu_pkg::*;

    logic [8:0] dot;
    logic [8:0] line;
    logic       dot_last;
    logic       line_last;

    assign dot_last  = (dot == 9'(DOTS_PER_LINE - 1));
    assign line_last = (line == 9'(LINES_PER_FRAME - 1));

    // ==========================================================
    // Counters
    // ==========================================================
    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            dot  <= 9'd0;
            line <= 9'd0;
        end else if (dot_last) begin
            dot <= 9'd0;
            if (line_last) begin
                line <= 9'd0;
            end else begin
                line <= line + 9'd1;
            end
        end else begin
            dot <= dot + 9'd1;
        end
    end

    // ==========================================================
    // Decode
    // ==========================================================
    always_comb begin
        timing.dot   = dot;
        timing.line  = line;
        timing.hsync = (dot >= 9'(HSYNC_START)) && (dot < 9'(HSYNC_END));
        timing.vsync = (line >= 9'(VSYNC_START)) && (line < 9'(VSYNC_END));
        timing.de    = (dot < 9'(VISIBLE_DOTS)) && (line < 9'(VISIBLE_LINES));
    end

    // Dot 1 of the VBlank start and pre-render lines
    assign vblank_set = (line == 9'(VBLANK_SET_LINE)) && (dot == 9'd1);
    assign vblank_clr = (line == 9'(VBLANK_CLR_LINE)) && (dot == 9'd1);

endmodule

//--- src/ppu_pkg.sv
// Shared definitions for the PPU core: register map, frame timing defaults
// and the structs passed between the register, timing, memory and render blocks
package ppu_pkg;

    // ==========================================================
    // Register map and address space
    // ==========================================================
    typedef enum logic [2:0] {
        REG_CTRL    = 3'd0,
        REG_MASK    = 3'd1,
        REG_STATUS  = 3'd2,
        REG_OAMADDR = 3'd3,
        REG_OAMDATA = 3'd4,
        REG_SCROLL  = 3'd5,
        REG_ADDR    = 3'd6,
        REG_DATA    = 3'd7
    } ppu_reg_e;

    localparam int VRAM_ADDR_W = 14;
    localparam int NT_ADDR_W   = 11;
    localparam int PAL_ADDR_W  = 5;

    // Pattern space below CHR_LIMIT, nametables up to the palette
    localparam logic [VRAM_ADDR_W-1:0] PALETTE_BASE = 14'h3F00;
    localparam logic [VRAM_ADDR_W-1:0] CHR_LIMIT    = 14'h2000;

    // ==========================================================
    // Frame timing
    // ==========================================================
    localparam int DOTS_PER_LINE_DEF   = 341;
    localparam int LINES_PER_FRAME_DEF = 262;
    localparam int VISIBLE_DOTS        = 256;
    localparam int VISIBLE_LINES       = 240;
    localparam int HSYNC_START         = 280;
    localparam int HSYNC_END           = 304;
    localparam int VSYNC_START         = 243;
    localparam int VSYNC_END           = 246;
    localparam int VBLANK_SET_LINE     = 241;
    localparam int VBLANK_CLR_LINE     = 261;

    // Color index shown outside the visible area
    localparam logic [5:0] BLANK_COLOR = 6'h0F;

    // ==========================================================
    // Bus structs
    // ==========================================================
    // Bit 4 of bg_table selects the table; bits 6:5 are kept but unused here
    typedef struct packed {
        logic       nmi_en;
        logic [2:0] bg_table;
        logic       spr_table;
        logic       incr32;
        logic [1:0] nt_sel;
    } ppu_ctrl_t;

    typedef struct packed {
        logic                   we;
        logic [VRAM_ADDR_W-1:0] addr;
        logic [7:0]             wdata;
    } cpu_vram_req_t;

    typedef struct packed {
        logic [NT_ADDR_W-1:0]  nt_addr;
        logic [PAL_ADDR_W-1:0] pal_idx;
    } render_req_t;

    typedef struct packed {
        logic [7:0] tile;
        logic [5:0] color;
    } render_rsp_t;

    typedef struct packed {
        logic [8:0] dot;
        logic [8:0] line;
        logic       hsync;
        logic       vsync;
        logic       de;
    } timing_t;

endpackage
